//--- isaPkg.sv
// Instruction-set definitions shared by the decoder, status logic and top level of the control unit
package isaPkg;

	// Instruction field widths, opcode in the upper bits of the byte
	localparam int OpcodeWidth = 5;
	localparam int CondWidth   = 3;

	// Status register bit positions
	localparam int FlagZ     = 0;
	localparam int FlagC     = 1;
	localparam int FlagV     = 2;
	localparam int FlagN     = 3;
	localparam int FlagWidth = 4;

	// Condition codes that select the INTERRUPT enable and disable forms
	localparam logic [CondWidth-1:0] IntCodeEnable  = 3'd1;
	localparam logic [CondWidth-1:0] IntCodeDisable = 3'd2;

	typedef logic [FlagWidth-1:0] flagsT;

	typedef enum logic [OpcodeWidth-1:0] {
		ADD       = 5'b00000,
		ADDI      = 5'b00001,
		ADC       = 5'b00010,
		SUB       = 5'b00100,
		SUBI      = 5'b00101,
		CMP       = 5'b00110,
		CMPI      = 5'b00111,
		AND       = 5'b01000,
		OR        = 5'b01001,
		XOR       = 5'b01010,
		NOT       = 5'b01011,
		LSL       = 5'b01100,
		LSR       = 5'b01101,
		LDW       = 5'b10100,
		STW       = 5'b10101,
		BRANCH    = 5'b11000,
		INTERRUPT = 5'b11100
	} opcodeT;

	// Branch condition field, codes 6 and 7 never branch
	typedef enum logic [CondWidth-1:0] {
		BR  = 3'd0,
		BNE = 3'd1,
		BE  = 3'd2,
		BLT = 3'd3,
		BGE = 3'd4,
		BWL = 3'd5
	} branchT;

endpackage

//--- controlPkg.sv
// Sequencer states, datapath select codes and control-word structs driven by the control unit
package controlPkg;

	typedef enum logic [1:0] {
		fetch,
		execute,
		interrupt
	} stateT;

	typedef enum logic [2:0] {
		cycle0,
		cycle1,
		cycle2,
		cycle3,
		cycle4
	} subCycleT;

	// Instruction classes, which decide how long execute runs
	typedef enum logic [2:0] {
		aluOp,
		compare,
		memory,
		branch,
		intCtl
	} instrClassT;

	typedef enum logic       {Op1Rd1, Op1Pc}            op1SelT;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero}  op2SelT;
	typedef enum logic       {ImmShort, ImmLong}        immSelT;
	typedef enum logic [1:0] {Pc1, PcAluOut, PcInt}     pcSelT;
	typedef enum logic       {WdAlu, WdSys}             wdSelT;
	typedef enum logic       {Rs1Ra, Rs1Rd}             rs1SelT;
	typedef enum logic       {NoOr, SubOr}              aluOrSelT;

	// External bus strobes, n-prefixed fields are active low
	typedef struct packed {
		logic ALE;
		logic nME;
		logic nOE;
		logic nWE;
		logic ENB;
		logic MemEn;
	} busCtlT;

	typedef struct packed {
		logic     AluEn;
		logic     AluWe;
		logic     RegWe;
		logic     PcEn;
		logic     PcWe;
		logic     IrWe;
		logic     LrWe;
		op1SelT   Op1Sel;
		op2SelT   Op2Sel;
		immSelT   ImmSel;
		pcSelT    PcSel;
		wdSelT    WdSel;
		rs1SelT   Rs1Sel;
		aluOrSelT AluOr;
	} dataCtlT;

	// Idle bus, memory deselected and no strobes
	localparam busCtlT BusIdle = '{ALE: 1'b0, nME: 1'b1, nOE: 1'b1, nWE: 1'b1,
		ENB: 1'b0, MemEn: 1'b0};

	localparam dataCtlT DataIdle = '{AluEn: 1'b0, AluWe: 1'b0, RegWe: 1'b0, PcEn: 1'b0,
		PcWe: 1'b0, IrWe: 1'b0, LrWe: 1'b0, Op1Sel: Op1Rd1, Op2Sel: Op2Imm,
		ImmSel: ImmLong, PcSel: Pc1, WdSel: WdAlu, Rs1Sel: Rs1Ra, AluOr: NoOr};

endpackage

//--- instructionDecode.sv
// Combinational decoder turning state, sub-cycle and opcode into bus and datapath control
module instructionDecode import isaPkg::*, controlPkg::*; (
	input  stateT                             state,
	input  subCycleT                          subCycle,
	input  logic [OpcodeWidth+CondWidth-1:0]  opcodeCond,
	input  logic                              branchTaken,
	input  logic                              nWait,
	output instrClassT                        instrClass,
	output busCtlT                            busCtl,
	output dataCtlT                           dataCtl,
	output logic                              statusWe,
	output logic                              intEnable,
	output logic                              intDisable
);

	opcodeT                opcode;
	logic [CondWidth-1:0]  cond;
	logic                  immForm;
	logic                  subForm;

	assign opcode = opcodeT'(opcodeCond[OpcodeWidth+CondWidth-1 -: OpcodeWidth]);
	assign cond   = opcodeCond[CondWidth-1:0];

	// Operand forms of the single-cycle ALU group
	assign immForm = (opcode == ADDI) || (opcode == SUBI) || (opcode == CMPI) ||
		(opcode == LSL) || (opcode == LSR);
	assign subForm = (opcode == SUB) || (opcode == SUBI) || (opcode == CMP) || (opcode == CMPI);

	always_comb begin
		case (opcode)
			ADD, ADDI, ADC, SUB, SUBI, AND, OR, XOR, NOT, LSL, LSR: instrClass = aluOp;
			CMP, CMPI:  instrClass = compare;
			LDW, STW:   instrClass = memory;
			BRANCH:     instrClass = branch;
			// Unknown opcodes just step the PC
			default:    instrClass = intCtl;
		endcase
	end

	always_comb begin
		busCtl     = BusIdle;
		dataCtl    = DataIdle;
		statusWe   = 1'b0;
		intEnable  = 1'b0;
		intDisable = 1'b0;
		case (state)
			fetch:
				case (subCycle)
					cycle0: begin
						busCtl.ALE    = 1'b1;
						dataCtl.PcEn  = 1'b1;
					end
					cycle1: begin
						busCtl.nME    = 1'b0;
						dataCtl.PcEn  = 1'b1;
					end
					cycle2: begin
						busCtl.nME    = 1'b0;
						busCtl.nOE    = 1'b0;
						busCtl.MemEn  = 1'b1;
						busCtl.ENB    = 1'b1;
						// Load only on the last wait cycle
						dataCtl.IrWe  = nWait;
					end
					cycle3: dataCtl.PcEn = 1'b1;
					default: ;
				endcase
			execute:
				case (subCycle)
					cycle4:
						case (instrClass)
							aluOp, compare: begin
								dataCtl.PcEn  = 1'b1;
								dataCtl.PcWe  = 1'b1;
								dataCtl.RegWe = (instrClass == aluOp);
								statusWe      = 1'b1;
								dataCtl.AluOr = subForm ? SubOr : NoOr;
								if (immForm)
									dataCtl.ImmSel = ImmShort;
								else if (opcode != NOT)
									dataCtl.Op2Sel = Op2Rd2;
							end
							memory: begin
								// Effective address into the ALU register
								dataCtl.AluEn  = 1'b1;
								dataCtl.AluWe  = 1'b1;
								dataCtl.ImmSel = ImmShort;
							end
							branch: begin
								dataCtl.AluEn  = 1'b1;
								dataCtl.PcWe   = 1'b1;
								dataCtl.Op1Sel = Op1Pc;
								dataCtl.PcSel  = branchTaken ? PcAluOut : Pc1;
								dataCtl.LrWe   = branchTaken && (cond == BWL);
							end
							default: begin
								dataCtl.PcEn  = 1'b1;
								dataCtl.PcWe  = 1'b1;
								intEnable     = (opcode == INTERRUPT) && (cond == IntCodeEnable);
								intDisable    = (opcode == INTERRUPT) && (cond == IntCodeDisable);
							end
						endcase
					cycle0: begin
						busCtl.ALE     = 1'b1;
						dataCtl.AluEn  = 1'b1;
						dataCtl.ImmSel = ImmShort;
					end
					cycle1: begin
						// Store data or pass-through value from Rd
						busCtl.nME     = 1'b0;
						dataCtl.AluEn  = 1'b1;
						dataCtl.AluWe  = 1'b1;
						dataCtl.Op2Sel = Op2Zero;
						dataCtl.Rs1Sel = Rs1Rd;
					end
					cycle2: begin
						busCtl.nME    = 1'b0;
						dataCtl.PcWe  = nWait;
						if (opcode == LDW) begin
							busCtl.nOE    = 1'b0;
							busCtl.MemEn  = 1'b1;
							busCtl.ENB    = 1'b1;
							dataCtl.WdSel = WdSys;
							dataCtl.RegWe = nWait;
						end else begin
							dataCtl.AluEn  = 1'b1;
							dataCtl.Op2Sel = Op2Zero;
						end
					end
					cycle3:
						if (opcode == STW) begin
							busCtl.nWE     = 1'b0;
							dataCtl.AluEn  = 1'b1;
							dataCtl.Op2Sel = Op2Zero;
						end else
							dataCtl.PcEn = 1'b1;
					default: ;
				endcase
			interrupt:
				case (subCycle)
					cycle4: intDisable = 1'b1;
					cycle2: dataCtl.PcEn = 1'b1;
					cycle3: begin
						dataCtl.PcEn  = 1'b1;
						dataCtl.PcWe  = 1'b1;
						dataCtl.PcSel = PcInt;
					end
					default: ;
				endcase
			default: ;
		endcase
	end

endmodule

//--- cycleSequencer.sv
// Major-state and sub-cycle register of the control unit, with wait states and interrupt entry
module cycleSequencer import controlPkg::*; (
	input  logic       Clock,
	input  logic       nReset,
	input  instrClassT instrClass,
	input  logic       intReq,
	input  logic       nWait,
	output stateT      state,
	output subCycleT   subCycle
);

	stateT    stateNext;
	subCycleT subCycleNext;
	logic     instrDone;

	always_comb begin
		stateNext    = state;
		subCycleNext = subCycle;
		instrDone    = 1'b0;
		case (state)
			fetch:
				case (subCycle)
					cycle0: subCycleNext = cycle1;
					cycle1: subCycleNext = cycle2;
					cycle2:
						// Memory not ready, hold the bus cycle
						if (nWait)
							subCycleNext = cycle3;
					cycle3: begin
						stateNext    = execute;
						subCycleNext = cycle4;
					end
					default: subCycleNext = cycle0;
				endcase
			execute:
				case (subCycle)
					cycle4:
						if (instrClass == memory)
							subCycleNext = cycle0;
						else
							instrDone = 1'b1;
					cycle0: subCycleNext = cycle1;
					cycle1: subCycleNext = cycle2;
					cycle2:
						if (nWait)
							subCycleNext = cycle3;
					cycle3: instrDone = 1'b1;
					default: instrDone = 1'b1;
				endcase
			interrupt:
				// Entry runs cycle4 then cycle0 to cycle3, no wait states
				case (subCycle)
					cycle4: subCycleNext = cycle0;
					cycle0: subCycleNext = cycle1;
					cycle1: subCycleNext = cycle2;
					cycle2: subCycleNext = cycle3;
					default: begin
						stateNext    = fetch;
						subCycleNext = cycle0;
					end
				endcase
			default: begin
				stateNext    = fetch;
				subCycleNext = cycle0;
			end
		endcase

		// Interrupts are taken only between instructions
		if (instrDone) begin
			if (intReq) begin
				stateNext    = interrupt;
				subCycleNext = cycle4;
			end else begin
				stateNext    = fetch;
				subCycleNext = cycle0;
			end
		end
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			state    <= fetch;
			subCycle <= cycle0;
		end else begin
			state    <= stateNext;
			subCycle <= subCycleNext;
		end
	end

endmodule

//--- statusFlags.sv
// Status register loaded from the ALU flags, with branch condition resolution for the decoder
module statusFlags import isaPkg::*; (
	input  logic   Clock,
	input  logic   nReset,
	input  flagsT  Flags,
	input  logic   statusWe,
	input  branchT cond,
	output flagsT  StatusReg,
	output logic   CFlag,
	output logic   branchTaken
);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			StatusReg <= '0;
		else if (statusWe)
			StatusReg <= Flags;
	end

	assign CFlag = StatusReg[FlagC];

	// Signed compare results use N against V
	always_comb begin
		case (cond)
			BR, BWL: branchTaken = 1'b1;
			BNE:     branchTaken = !StatusReg[FlagZ];
			BE:      branchTaken = StatusReg[FlagZ];
			BLT:     branchTaken = StatusReg[FlagN] != StatusReg[FlagV];
			BGE:     branchTaken = StatusReg[FlagN] == StatusReg[FlagV];
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

//--- interruptControl.sv
// Interrupt request synchronizer and enable flag feeding the cycle sequencer
module interruptControl (
	input  logic Clock,
	input  logic nReset,
	input  logic nIRQ,
	input  logic intEnable,
	input  logic intDisable,
	output logic intReq
);

	logic irqSync1;
	logic irqSync2;
	logic intEnabled;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqSync1   <= 1'b0;
			irqSync2   <= 1'b0;
			intEnabled <= 1'b0;
		end else begin
			irqSync1 <= !nIRQ;
			irqSync2 <= irqSync1;
			// Disable wins over a same-cycle enable
			if (intDisable)
				intEnabled <= 1'b0;
			else if (intEnable)
				intEnabled <= 1'b1;
		end
	end

	assign intReq = irqSync2 && intEnabled;

endmodule

//--- cpuControl.sv
// Top level of the processor control unit, joining decoder, sequencer, status and interrupt logic
module cpuControl import isaPkg::*, controlPkg::*; (
	input  logic                             Clock,
	input  logic                             nReset,
	input  logic [OpcodeWidth+CondWidth-1:0] OpcodeCondIn,
	input  flagsT                            Flags,
	input  logic                             nIRQ,
	input  logic                             nWait,
	output busCtlT                           busCtl,
	output dataCtlT                          dataCtl,
	output flagsT                            StatusReg,
	output logic                             CFlag
);

	stateT      state;
	subCycleT   subCycle;
	instrClassT instrClass;
	logic       statusWe;
	logic       intEnable;
	logic       intDisable;
	logic       branchTaken;
	logic       intReq;

	instructionDecode i_decode (
		.state       (state),
		.subCycle    (subCycle),
		.opcodeCond  (OpcodeCondIn),
		.branchTaken (branchTaken),
		.nWait       (nWait),
		.instrClass  (instrClass),
		.busCtl      (busCtl),
		.dataCtl     (dataCtl),
		.statusWe    (statusWe),
		.intEnable   (intEnable),
		.intDisable  (intDisable)
	);

	cycleSequencer i_sequencer (
		.Clock      (Clock),
		.nReset     (nReset),
		.instrClass (instrClass),
		.intReq     (intReq),
		.nWait      (nWait),
		.state      (state),
		.subCycle   (subCycle)
	);

	// Condition field is the low bits of the instruction byte
	statusFlags i_status (
		.Clock       (Clock),
		.nReset      (nReset),
		.Flags       (Flags),
		.statusWe    (statusWe),
		.cond        (branchT'(OpcodeCondIn[CondWidth-1:0])),
		.StatusReg   (StatusReg),
		.CFlag       (CFlag),
		.branchTaken (branchTaken)
	);

	interruptControl i_interrupt (
		.Clock      (Clock),
		.nReset     (nReset),
		.nIRQ       (nIRQ),
		.intEnable  (intEnable),
		.intDisable (intDisable),
		.intReq     (intReq)
	);

endmodule

//--- cpuControl_chk.sv
// Assertions on bus strobes, the wait handshake and reset behavior; bound into cpuControl
module cpuControl_chk import controlPkg::*; (
	input logic    Clock,
	input logic    nReset,
	input busCtlT  busCtl,
	input dataCtlT dataCtl,
	input logic    nWait
);

	logic anyWrite;

	assign anyWrite = dataCtl.RegWe || dataCtl.PcWe || dataCtl.IrWe || dataCtl.LrWe ||
		dataCtl.AluWe;

	// Address latch and memory select never overlap
	aleNoSelect: assert property (@(posedge Clock) disable iff (!nReset)
		!(busCtl.ALE && !busCtl.nME))
		else $error("ALE high while nME is low");

	irWaitHold: assert property (@(posedge Clock) disable iff (!nReset)
		!(dataCtl.IrWe && !nWait))
		else $error("IrWe high during a wait state");

	resetQuiet: assert property (@(posedge Clock) !nReset |-> !anyWrite && busCtl.nME)
		else $error("write enable or memory select active during reset");

endmodule

//--- cpuControl_tb.sv
// Testbench for the control unit; reads instruction vectors, acts as memory and checks control outputs
module cpuControl_tb import isaPkg::*, controlPkg::*; ();

	localparam int ClockPeriod  = 10;
	localparam int ResetCycles  = 10;
	localparam int NumVectors   = 18;
	localparam int VecFields    = 6;
	localparam int CyclesPerVec = 60;

	logic       Clock;
	logic       nReset;
	logic [7:0] OpcodeCondIn;
	flagsT      Flags;
	logic       nIRQ;
	logic       nWait;
	busCtlT     busCtl;
	dataCtlT    dataCtl;
	flagsT      StatusReg;
	logic       CFlag;

	// Six hex bytes per instruction, see the vector file
	logic [7:0] vectors [0:NumVectors*VecFields-1];
	logic [7:0] nextOpcode;
	flagsT      nextFlags;
	logic       nextNIrq;
	flagsT      statusModel;
	logic       intEnabledModel;
	logic       cycle0Seen;
	int         errorCount;
	int         checkCount;

	cpuControl i_dut (
		.Clock        (Clock),
		.nReset       (nReset),
		.OpcodeCondIn (OpcodeCondIn),
		.Flags        (Flags),
		.nIRQ         (nIRQ),
		.nWait        (nWait),
		.busCtl       (busCtl),
		.dataCtl      (dataCtl),
		.StatusReg    (StatusReg),
		.CFlag        (CFlag)
	);

	bind cpuControl cpuControl_chk i_chk (
		.Clock   (Clock),
		.nReset  (nReset),
		.busCtl  (busCtl),
		.dataCtl (dataCtl),
		.nWait   (nWait)
	);

	initial begin
		Clock = 1'b0;
		forever #(ClockPeriod / 2) Clock = !Clock;
	end

	// Runaway guard
	initial begin
		#((NumVectors * CyclesPerVec + ResetCycles) * ClockPeriod);
		$display("Timeout: the run did not finish within %0d cycles",
			NumVectors * CyclesPerVec + ResetCycles);
		$display("Test failed");
		$finish;
	end

	task automatic check(input logic ok, input string msg);
		checkCount++;
		assert (ok) else begin
			errorCount++;
			$display("error at %0t: %s", $time, msg);
		end
	endtask

	// Inputs change just after the edge, outputs are read mid-cycle
	task automatic stepCycle();
		@(posedge Clock);
		#1;
		OpcodeCondIn = nextOpcode;
		Flags        = nextFlags;
		nIRQ         = nextNIrq;
		nWait        = ($urandom % 3) != 0;
		@(negedge Clock);
	endtask

	function automatic logic branchRule(input logic [2:0] cond, input flagsT sr);
		case (cond)
			BR, BWL: return 1'b1;
			BNE:     return !sr[FlagZ];
			BE:      return sr[FlagZ];
			BLT:     return sr[FlagN] != sr[FlagV];
			BGE:     return sr[FlagN] == sr[FlagV];
			default: return 1'b0;
		endcase
	endfunction

	task automatic fetchInstruction(input logic [7:0] op);
		int irCount;
		irCount = 0;
		if (!cycle0Seen)
			stepCycle();
		cycle0Seen = 1'b0;
		check(busCtl.ALE && !dataCtl.IrWe, "fetch did not start with ALE");
		check(StatusReg == statusModel && CFlag == statusModel[FlagC],
			$sformatf("StatusReg %h CFlag %b, expected %h", StatusReg, CFlag, statusModel));
		// Memory stays selected through any wait states
		do begin
			stepCycle();
			check(!busCtl.nME, "nME went high before the instruction was loaded");
			if (dataCtl.IrWe)
				irCount++;
		end while (!dataCtl.IrWe);
		nextOpcode = op;
		stepCycle();
		if (dataCtl.IrWe)
			irCount++;
		check(irCount == 1, $sformatf("IrWe pulsed %0d times in one fetch", irCount));
	endtask

	task automatic executeInstruction(input int k);
		logic [7:0] op;
		opcodeT     opc;
		logic [2:0] cond;
		logic       expReg;
		logic       expBr;
		int         regCount;
		int         nWeCount;
		op       = vectors[k*VecFields];
		opc      = opcodeT'(op[7:3]);
		cond     = op[2:0];
		expReg   = vectors[k*VecFields+3][0];
		expBr    = vectors[k*VecFields+4][0];
		regCount = 0;
		nWeCount = 0;
		stepCycle();
		case (opc)
			LDW, STW: begin
				// Address phase, then the data bus cycle until PcWe completes it
				do begin
					stepCycle();
					if (dataCtl.RegWe)
						regCount++;
					if (!busCtl.nWE)
						nWeCount++;
				end while (!dataCtl.PcWe);
				check(dataCtl.RegWe == expReg && (opc != LDW || dataCtl.WdSel == WdSys),
					$sformatf("op %h RegWe %b WdSel %0d in final cycle2", op, dataCtl.RegWe,
					dataCtl.WdSel));
				stepCycle();
				if (!busCtl.nWE)
					nWeCount++;
				check(regCount == int'(expReg), $sformatf("op %h RegWe count %0d", op, regCount));
				check(nWeCount == ((opc == STW) ? 1 : 0),
					$sformatf("op %h nWE low in %0d cycles", op, nWeCount));
			end
			BRANCH: begin
				check(expBr == branchRule(cond, statusModel),
					$sformatf("vector %0d has a branch column that breaks the condition rule", k));
				check(dataCtl.PcWe && (dataCtl.PcSel == PcAluOut) == expBr,
					$sformatf("branch %0d PcSel %0d, expected taken %b", cond, dataCtl.PcSel, expBr));
				check(dataCtl.LrWe == (expBr && cond == BWL),
					$sformatf("branch %0d LrWe %b", cond, dataCtl.LrWe));
			end
			INTERRUPT: begin
				check(dataCtl.PcWe && !dataCtl.RegWe, $sformatf("op %h bad write enables", op));
				if (cond == IntCodeEnable)
					intEnabledModel = 1'b1;
				else if (cond == IntCodeDisable)
					intEnabledModel = 1'b0;
			end
			default: begin
				// ALU and compare group, status loads at the end of this cycle
				check(dataCtl.PcWe && dataCtl.RegWe == expReg,
					$sformatf("op %h PcWe %b RegWe %b", op, dataCtl.PcWe, dataCtl.RegWe));
				statusModel = vectors[k*VecFields+1][FlagWidth-1:0];
			end
		endcase
	endtask

	task automatic finishInstruction(input logic expInt);
		logic taken;
		stepCycle();
		// Interrupt cycle4 has no ALE, a new fetch does
		taken = !busCtl.ALE;
		if (taken) begin
			repeat (4) stepCycle();
			check(dataCtl.PcWe && dataCtl.PcSel == PcInt,
				$sformatf("entry ended with PcWe %b PcSel %0d", dataCtl.PcWe, dataCtl.PcSel));
			intEnabledModel = 1'b0;
		end else
			cycle0Seen = 1'b1;
		check(taken == expInt, $sformatf("interrupt taken %b, expected %b", taken, expInt));
		nextNIrq = 1'b1;
	endtask

	initial begin
		void'($urandom(32'hdc70));
		errorCount      = 0;
		checkCount      = 0;
		nReset          = 1'b0;
		OpcodeCondIn    = '0;
		Flags           = '0;
		nIRQ            = 1'b1;
		nWait           = 1'b1;
		nextOpcode      = '0;
		nextFlags       = '0;
		nextNIrq        = 1'b1;
		statusModel     = '0;
		intEnabledModel = 1'b0;
		cycle0Seen      = 1'b0;
		$readmemh("cpuControlVectors.txt", vectors);
		repeat (ResetCycles) @(posedge Clock);
		#1;
		nReset = 1'b1;
		@(negedge Clock);
		cycle0Seen = 1'b1;
		for (int k = 0; k < NumVectors; k++) begin
			nextFlags = vectors[k*VecFields+1][FlagWidth-1:0];
			nextNIrq  = !vectors[k*VecFields+2][0];
			check(vectors[k*VecFields+5][0] == (vectors[k*VecFields+2][0] && intEnabledModel),
				$sformatf("vector %0d has an interrupt column that breaks the enable state", k));
			fetchInstruction(vectors[k*VecFields]);
			executeInstruction(k);
			finishInstruction(vectors[k*VecFields+5][0]);
		end
		check(StatusReg == statusModel,
			$sformatf("final StatusReg %h, expected %h", StatusReg, statusModel));
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- cpuControlVectors.txt
// columns: opcodeCond flags irq, then expected regWrite branchTaken intTaken
// hex bytes, one instruction per line, flags bits are N V C Z from high to low
00 02 00 01 00 00
30 01 00 00 00 00
c1 00 00 00 00 00
c2 00 00 00 01 00
28 08 00 01 00 00
c3 00 00 00 01 00
c4 00 00 00 00 00
c5 00 00 00 01 00
a0 00 00 01 00 00
a8 00 00 00 00 00
e1 00 00 00 00 00
10 04 01 01 00 01
38 0c 01 00 00 00
c4 00 00 00 01 00
e1 00 00 00 00 00
a0 00 01 01 00 01
e2 00 00 00 00 00
50 03 01 01 00 00

//--- cpuControl.f
isaPkg.sv
controlPkg.sv
instructionDecode.sv
cycleSequencer.sv
statusFlags.sv
interruptControl.sv
cpuControl.sv
cpuControl_chk.sv
cpuControl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the control unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module cpuControl_tb \
	-f cpuControl.f --Mdir obj_dir -o cpuControl_sim > build.log 2>&1; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/cpuControl_sim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "FAIL"
	exit 1
fi
if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi
echo "PASS"
exit 0
